// File: Makefile
VERILATOR ?= verilator
TOP       := dispatch_tb
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_TOP  := dispatch_top
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dispatch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_defines.svh"

module dispatch_tb;

    import iq_pkg::*;

    localparam int NUM_INSTR     = 400;
    localparam int CYCLE_NS      = 100;
    localparam int NO_COMMIT_CYC = 200; // ROB fills and stays full early on.
    localparam int BCAST_EVERY   = 50;
    // at most 60 cycles per instruction, plus the start-up phase.
    localparam int WATCHDOG_NS   = (NUM_INSTR * 60 + NO_COMMIT_CYC + 100) * CYCLE_NS;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr_word;
    logic        rs_valid;
    logic        rs_ready;
    rs_entry_t   rs_entry;
    logic        commit;
    logic        cdb_valid;
    rob_tag_t    cdb_tag;

    rs_entry_t   exp_q [$]; // predicted entries in program order.
    rs_entry_t   exp_head;
    int          exp_count;
    logic        model_busy [`NUM_REGS];
    rob_tag_t    model_tag [`NUM_REGS];
    int          tag_count;
    int          in_rob;    // entries seen at the output and not yet committed.
    int          accepted;
    int          pushed;
    int          handshakes;
    logic        started;
    logic        took_last;
    int          stall_left;
    logic        stall_low;
    int          cycle;
    int          next_bcast;

    tb_clock #(.PERIOD_NS(CYCLE_NS)) u_clock (.clk(clk));

    dispatch_top dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr_word),
        .rs_valid    (rs_valid),
        .rs_ready    (rs_ready),
        .rs_entry    (rs_entry),
        .commit      (commit),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag)
    );

    task automatic report_error(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "%s", msg);
    endtask

    // fields by bit position: op 31:27, rd 26:22, rs1 21:17, rs2 16:12, imm 16:0.
    function automatic iq_entry_t expected_decode(logic [31:0] w);
        iq_entry_t e;
        e.opcode = w[31:27];
        e.rd     = w[26:22];
        e.rs1    = w[21:17];
        if (w[31]) begin
            e.rs2     = '0;
            e.imm     = {{15{w[16]}}, w[16:0]};
            e.has_imm = 1'b1;
        end else begin
            e.rs2     = w[16:12];
            e.imm     = '0;
            e.has_imm = 1'b0;
        end
        return e;
    endfunction

    function automatic src_info_t expected_source(reg_idx_t r);
        src_info_t s;
        s.busy = model_busy[r];
        s.tag  = model_busy[r] ? model_tag[r] : '0;
        return s;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom();
        w[31:27] = ($urandom_range(7) == 0) ? `NOP_OP : 5'($urandom_range(30));
        w[26:22] = 5'($urandom_range(7)); // few registers, so sources collide.
        w[21:17] = 5'($urandom_range(7));
        if (!w[31]) begin
            w[16:12] = 5'($urandom_range(7));
        end
        return w;
    endfunction

    // in-order model, updated at each edge.
    always @(posedge clk) begin
        rs_entry_t e;
        if (!rst) begin
            exp_q.delete();
            for (int r = 0; r < `NUM_REGS; r++) begin
                model_busy[r] = 1'b0;
            end
            tag_count  = 0;
            in_rob     = 0;
            accepted   = 0;
            pushed     = 0;
            handshakes = 0;
            started    = 1'b0;
            took_last  = 1'b0;
        end else begin
            if (cdb_valid) begin
                for (int r = 0; r < `NUM_REGS; r++) begin
                    if (model_busy[r] && model_tag[r] == cdb_tag) begin
                        model_busy[r] = 1'b0;
                    end
                end
            end
            if (rs_valid && rs_ready) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                handshakes++;
                in_rob++;
            end
            if (commit && in_rob > 0) begin
                in_rob--;
            end
            took_last = instr_valid && instr_ready;
            if (took_last) begin
                started = 1'b1;
                accepted++;
                if (instr_word[31:27] != `NOP_OP) begin
                    e.instr    = expected_decode(instr_word);
                    e.dest_tag = rob_tag_t'(tag_count % `ROB_DEPTH);
                    e.src1     = expected_source(e.instr.rs1);
                    e.src2     = expected_source(e.instr.rs2);
                    if (e.instr.rd != '0) begin
                        model_busy[e.instr.rd] = 1'b1;
                        model_tag[e.instr.rd]  = e.dest_tag;
                    end
                    tag_count++;
                    pushed++;
                    exp_q.push_back(e);
                end
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (!rst)
        !started |-> (!rs_valid && instr_ready)
    ) else report_error("output active or input blocked before the first instruction");

    nothing_extra: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (exp_count != 0)
    ) else report_error("entry appeared with none expected");

    instr_match: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (rs_entry.instr == exp_head.instr)
    ) else report_error("instruction fields differ from the model");

    no_nop_out: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (rs_entry.instr.opcode != `NOP_OP)
    ) else report_error("no-op word reached the output");

    tag_order: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (rs_entry.dest_tag == exp_head.dest_tag)
    ) else report_error("destination tag out of dispatch order");

    src1_match: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (rs_entry.src1.busy == exp_head.src1.busy
            && (!exp_head.src1.busy || rs_entry.src1.tag == exp_head.src1.tag))
    ) else report_error("rs1 source info differs from the model");

    src2_match: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> (rs_entry.src2.busy == exp_head.src2.busy
            && (!exp_head.src2.busy || rs_entry.src2.tag == exp_head.src2.tag))
    ) else report_error("rs2 source info differs from the model");

    reg0_ready: assert property (@(posedge clk) disable iff (!rst)
        rs_valid |-> ((rs_entry.instr.rs1 != '0 || !rs_entry.src1.busy)
            && (rs_entry.instr.rs2 != '0 || !rs_entry.src2.busy))
    ) else report_error("register 0 reported busy");

    rob_bound: assert property (@(posedge clk) disable iff (!rst)
        in_rob <= `ROB_DEPTH
    ) else report_error("more entries out than free ROB tags");

    stall_hold: assert property (@(posedge clk) disable iff (!rst)
        (rs_valid && !rs_ready) |=> (rs_valid && $stable(rs_entry))
    ) else report_error("rs_entry changed while stalled");

    ready_only_when_full: assert property (@(posedge clk) disable iff (!rst)
        !instr_ready |-> (exp_count >= `IQ_DEPTH + 1)
    ) else report_error("instr_ready low before queue and decoder are full");

    full_blocks_input: assert property (@(posedge clk) disable iff (!rst)
        (exp_count == `IQ_DEPTH + 2 && !rs_ready) |-> !instr_ready
    ) else report_error("instr_ready high with every stage full");

    task automatic drive_cycle();
        // an offered word is held until taken.
        if (!(instr_valid && !took_last)) begin
            instr_valid = ($urandom_range(3) != 0);
            instr_word  = random_word();
        end
        if (stall_left == 0) begin
            stall_low  = ($urandom_range(2) == 0);
            stall_left = stall_low ? $urandom_range(40, 5) : $urandom_range(12, 1);
        end
        stall_left--;
        rs_ready = !stall_low;
        commit   = (cycle > NO_COMMIT_CYC) && (in_rob > 0) && ($urandom_range(2) != 0);
        cycle++;
    endtask

    task automatic drain();
        instr_valid = 1'b0;
        rs_ready    = 1'b1;
        while (exp_count != 0 || rs_valid) begin
            @(negedge clk);
            commit = (in_rob > 0) && ($urandom_range(1) != 0);
        end
        commit = 1'b0;
    endtask

    task automatic broadcast_tags();
        repeat (3) begin
            @(negedge clk);
            cdb_valid = 1'b1;
            cdb_tag   = rob_tag_t'($urandom_range(`ROB_DEPTH - 1));
        end
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    initial begin
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr_word  = '0;
        rs_ready    = 1'b0;
        commit      = 1'b0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        stall_left  = 0;
        stall_low   = 1'b0;
        cycle       = 0;
        next_bcast  = BCAST_EVERY;
        void'($urandom(32'h9d8a));
        repeat (3) @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        while (accepted < NUM_INSTR) begin
            if (accepted >= next_bcast) begin
                drain(); // broadcasts only with the pipeline empty.
                broadcast_tags();
                next_bcast += BCAST_EVERY;
            end
            drive_cycle();
            @(negedge clk);
        end
        drain();
        repeat (4) @(negedge clk);
        if (handshakes != pushed || rs_valid) begin
            report_error("entries lost or repeated at the end of the run");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: dispatch_top.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      instr_valid,
    output logic                     instr_ready,
    input  wire iq_pkg::instr_word_u instr,
    output logic                     rs_valid,
    input  wire                      rs_ready,
    output iq_pkg::rs_entry_t        rs_entry,
    input  wire                      commit,
    input  wire                      cdb_valid,
    input  wire iq_pkg::rob_tag_t    cdb_tag
);

    import iq_pkg::*;

    logic      dec_valid;
    logic      dec_ready;
    iq_entry_t dec_entry;
    logic      head_valid;
    logic      head_ready;
    iq_entry_t head;
    rob_tag_t  next_tag;
    logic      rob_free;
    logic      alloc;
    src_info_t rs1_info;
    src_info_t rs2_info;
    logic      rename_valid;
    reg_idx_t  rename_reg;
    rob_tag_t  rename_tag;

    instr_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .out_valid   (dec_valid),
        .out_ready   (dec_ready),
        .out_entry   (dec_entry)
    );

    instr_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (dec_valid),
        .in_ready   (dec_ready),
        .in_entry   (dec_entry),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head       (head)
    );

    rob_alloc u_rob_alloc (
        .clk      (clk),
        .rst      (rst),
        .alloc    (alloc),
        .commit   (commit),
        .next_tag (next_tag),
        .rob_free (rob_free)
    );

    reg_status u_reg_status (
        .clk          (clk),
        .rst          (rst),
        .rs1_idx      (head.rs1),
        .rs2_idx      (head.rs2),
        .rs1_info     (rs1_info),
        .rs2_info     (rs2_info),
        .rename_valid (rename_valid),
        .rename_reg   (rename_reg),
        .rename_tag   (rename_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag)
    );

    dispatch_unit u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head_ready   (head_ready),
        .head         (head),
        .next_tag     (next_tag),
        .rob_free     (rob_free),
        .alloc        (alloc),
        .rs1_info     (rs1_info),
        .rs2_info     (rs2_info),
        .rename_valid (rename_valid),
        .rename_reg   (rename_reg),
        .rename_tag   (rename_tag),
        .rs_valid     (rs_valid),
        .rs_ready     (rs_ready),
        .rs_entry     (rs_entry)
    );

endmodule

`default_nettype wire

// File: dispatch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch_unit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    head_valid,
    output logic                   head_ready,
    input  wire iq_pkg::iq_entry_t head,
    input  wire iq_pkg::rob_tag_t  next_tag,
    input  wire                    rob_free,
    output logic                   alloc,
    input  wire iq_pkg::src_info_t rs1_info,
    input  wire iq_pkg::src_info_t rs2_info,
    output logic                   rename_valid,
    output iq_pkg::reg_idx_t       rename_reg,
    output iq_pkg::rob_tag_t       rename_tag,
    output logic                   rs_valid,
    input  wire                    rs_ready,
    output iq_pkg::rs_entry_t      rs_entry
);

    import iq_pkg::*;

    logic fire;

    // head present, a tag free and room in the output register.
    assign fire = head_valid && rob_free && (!rs_valid || rs_ready);

    assign head_ready   = fire;
    assign alloc        = fire;
    assign rename_valid = fire;
    assign rename_reg   = head.rd;
    assign rename_tag   = next_tag;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rs_valid <= 1'b0;
        end else if (fire) begin
            rs_valid <= 1'b1;
        end else if (rs_ready) begin
            rs_valid <= 1'b0;
        end
    end

    // sources are looked up before this instruction's own rename lands.
    always_ff @(posedge clk) begin
        if (fire) begin
            rs_entry.instr    <= head;
            rs_entry.dest_tag <= next_tag;
            rs_entry.src1     <= rs1_info;
            rs_entry.src2     <= rs2_info;
        end
    end

    hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst)
        (rs_valid && !rs_ready) |=> (rs_valid && $stable(rs_entry))
    ) else $error("rs_entry changed while stalled.");

endmodule

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_defines.svh"

module instr_decoder (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      instr_valid,
    output logic                     instr_ready,
    input  wire iq_pkg::instr_word_u instr,
    output logic                     out_valid,
    input  wire                      out_ready,
    output iq_pkg::iq_entry_t        out_entry
);

    import iq_pkg::*;

    logic      take;
    logic      is_nop;
    iq_entry_t decoded;

    // accept when the output register is empty or draining.
    assign instr_ready = !out_valid || out_ready;
    assign take = instr_valid && instr_ready;
    assign is_nop = (instr.r_form.opcode == `NOP_OP);

    always_comb begin
        decoded.opcode = instr.r_form.opcode;
        decoded.rd     = instr.r_form.rd; // same place in both formats.
        decoded.rs1    = instr.r_form.rs1;
        if (is_imm_op(instr.r_form.opcode)) begin
            decoded.rs2     = '0;
            decoded.imm     = {{15{instr.i_form.imm[16]}}, instr.i_form.imm};
            decoded.has_imm = 1'b1;
        end else begin
            decoded.rs2     = instr.r_form.rs2;
            decoded.imm     = '0;
            decoded.has_imm = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= !is_nop; // no-ops are swallowed here.
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_entry <= decoded;
        end
    end

endmodule

`default_nettype wire

// File: instr_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_defines.svh"

module instr_queue (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire iq_pkg::iq_entry_t in_entry,
    output logic                   head_valid,
    input  wire                    head_ready,
    output iq_pkg::iq_entry_t      head
);

    import iq_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    iq_entry_t        mem [`IQ_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(`IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full       = (count == (PTR_W+1)'(`IQ_DEPTH));
    assign head_valid = (count != '0);
    assign head       = mem[head_ptr];

    // a full queue still takes a word when the head leaves in the same cycle.
    assign in_ready = !full || head_ready;

    assign push = in_valid && in_ready;
    assign pop  = head_valid && head_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= ptr_inc(tail_ptr);
            end
            if (pop) begin
                head_ptr <= ptr_inc(head_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_ptr] <= in_entry;
        end
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        count <= (PTR_W+1)'(`IQ_DEPTH)
    ) else $error("queue count above depth.");

    // the dispatch side only asks for the head when there is one.
    no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst)
        head_ready |-> (count != '0)
    ) else $error("pop requested from an empty queue.");

endmodule

`default_nettype wire

// File: iq_defines.svh
`ifndef IQ_DEFINES_SVH
`define IQ_DEFINES_SVH

// instruction queue entries.
`define IQ_DEPTH 16

// reorder buffer tags in flight.
`define ROB_DEPTH 8

`define NUM_REGS 32 // architectural registers.

// opcode of an empty or no-op word.
`define NOP_OP 5'd31

`endif

// File: iq_pkg.sv
`default_nettype none

`include "iq_defines.svh"

package iq_pkg;

    typedef logic [4:0] op_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // immediate form when the top opcode bit is set.
    function automatic logic is_imm_op(op_t op);
        return op[4];
    endfunction

    typedef struct packed {
        op_t         opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] pad;
    } r_form_t;

    typedef struct packed {
        op_t         opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [16:0] imm; // signed.
    } i_form_t;

    // one 32-bit word, read as either format.
    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_word_u;

    typedef struct packed {
        op_t         opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [31:0] imm;
        logic        has_imm;
    } iq_entry_t;

    typedef struct packed {
        logic     busy;
        rob_tag_t tag; // producer, zero when not busy.
    } src_info_t;

    typedef struct packed {
        iq_entry_t instr;
        rob_tag_t  dest_tag;
        src_info_t src1;
        src_info_t src2;
    } rs_entry_t;

endpackage

`default_nettype wire

// File: reg_status.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_defines.svh"

module reg_status (
    input  wire                   clk,
    input  wire                   rst,
    input  wire iq_pkg::reg_idx_t rs1_idx,
    input  wire iq_pkg::reg_idx_t rs2_idx,
    output iq_pkg::src_info_t     rs1_info,
    output iq_pkg::src_info_t     rs2_info,
    input  wire                   rename_valid,
    input  wire iq_pkg::reg_idx_t rename_reg,
    input  wire iq_pkg::rob_tag_t rename_tag,
    input  wire                   cdb_valid,
    input  wire iq_pkg::rob_tag_t cdb_tag
);

    import iq_pkg::*;

    logic [`NUM_REGS-1:0] busy;
    rob_tag_t             prod_tag [`NUM_REGS];
    logic                 rs1_live;
    logic                 rs2_live;
    logic                 do_rename;

    assign do_rename = rename_valid && (rename_reg != '0); // r0 stays ready.

    // a broadcast in the same cycle already counts as done.
    assign rs1_live = busy[rs1_idx] && !(cdb_valid && prod_tag[rs1_idx] == cdb_tag);
    assign rs2_live = busy[rs2_idx] && !(cdb_valid && prod_tag[rs2_idx] == cdb_tag);

    always_comb begin
        rs1_info.busy = rs1_live;
        rs1_info.tag  = rs1_live ? prod_tag[rs1_idx] : '0;
        rs2_info.busy = rs2_live;
        rs2_info.tag  = rs2_live ? prod_tag[rs2_idx] : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                if (cdb_valid && busy[r] && prod_tag[r] == cdb_tag) begin
                    busy[r] <= 1'b0;
                end
            end
            if (do_rename) begin
                busy[rename_reg] <= 1'b1; // overrides a clear in the same cycle.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_rename) begin
            prod_tag[rename_reg] <= rename_tag;
        end
    end

endmodule

`default_nettype wire

// File: rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "iq_defines.svh"

module rob_alloc (
    input  wire              clk,
    input  wire              rst,
    input  wire              alloc,
    input  wire              commit,
    output iq_pkg::rob_tag_t next_tag,
    output logic             rob_free
);

    import iq_pkg::*;

    localparam int TAG_W = $bits(rob_tag_t);
    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    rob_tag_t         alloc_ptr;
    logic [CNT_W-1:0] used; // tags between oldest and next.
    logic             do_commit;

    assign next_tag  = alloc_ptr;
    assign rob_free  = (used != CNT_W'(`ROB_DEPTH));
    assign do_commit = commit && (used != '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            alloc_ptr <= '0;
            used      <= '0;
        end else begin
            if (alloc) begin
                alloc_ptr <= (alloc_ptr == TAG_W'(`ROB_DEPTH - 1)) ? '0 : alloc_ptr + 1'b1;
            end
            case ({alloc, do_commit})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1; // oldest tag released.
                default: used <= used;
            endcase
        end
    end

    // dispatch must wait for a free tag.
    alloc_when_free: assert property (
        @(posedge clk) disable iff (!rst)
        alloc |-> rob_free
    ) else $error("tag allocated with the ROB full.");

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
iq_pkg.sv
instr_decoder.sv
instr_queue.sv
rob_alloc.sv
reg_status.sv
dispatch_unit.sv
dispatch_top.sv
tb_clock.sv
dispatch_tb.sv

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
